//--- logic/bus_write_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bus_write_decoder (
    input  logic                                 i_EMUCLK,
    input  logic                                 mrst_n,
    input  logic                                 i_cs_n,
    input  logic                                 i_wr_n,
    input  logic                                 i_rd_n,
    input  logic                                 i_a0,
    input  logic [opm_map_pkg::data_w-1:0]       i_d,
    output logic [opm_map_pkg::data_w-1:0]       o_d,
    output logic                                 o_d_oe,
    output logic                                 o_ne,
    output logic [opm_map_pkg::nfrq_w-1:0]       o_nfrq,
    output logic [7:0]                           o_clka1,
    output logic [opm_map_pkg::clka2_w-1:0]      o_clka2,
    output logic [7:0]                           o_clkb,
    output logic [7:0]                           o_lfrq,
    output logic [opm_map_pkg::data_w-1:0]       o_wr_data,
    output logic [opm_map_pkg::num_groups-1:0]   o_grp_we,
    output opm_slot_pkg::slot_t                  o_slot_cnt
);

    //////////////////////////////////////////////////
    // bus synchronizer and write strobes

    logic [1:0]                               cs_n_sync, wr_n_sync, a0_sync;
    logic [1:0][opm_map_pkg::data_w-1:0]      d_sync;
    logic                                     wr_n_dly;      // edge detect stage
    logic                                     wr_fall;
    logic                                     addr_stb, data_stb;
    logic [opm_map_pkg::data_w-1:0]           bus_byte;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            cs_n_sync <= 2'b11;
            wr_n_sync <= 2'b11;
            a0_sync   <= 2'b00;
            d_sync    <= '0;
            wr_n_dly  <= 1'b1;
        end else begin
            cs_n_sync <= {cs_n_sync[0], i_cs_n};
            wr_n_sync <= {wr_n_sync[0], i_wr_n};
            a0_sync   <= {a0_sync[0], i_a0};
            d_sync    <= {d_sync[0], i_d};
            wr_n_dly  <= wr_n_sync[1];
        end
    end

    assign wr_fall = wr_n_dly & ~wr_n_sync[1] & ~cs_n_sync[1];

    // one-cycle strobes, byte captured alongside
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            addr_stb <= 1'b0;
            data_stb <= 1'b0;
            bus_byte <= '0;
        end else begin
            addr_stb <= wr_fall & ~a0_sync[1];
            data_stb <= wr_fall & a0_sync[1];
            if (wr_fall) bus_byte <= d_sync[1];
        end
    end

    //////////////////////////////////////////////////
    // address register and decode

    logic [7:0]              addr_q;
    logic                    addr_is_op;   // 0x40..0xFF
    opm_map_pkg::group_e     addr_grp;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) addr_q <= '0;
        else if (addr_stb) addr_q <= bus_byte;
    end

    always_comb begin
        addr_is_op = 1'b1;
        addr_grp   = opm_map_pkg::grp_dt1_mul;
        case (addr_q[7:5])
            opm_map_pkg::base_dt1_mul:  addr_grp = opm_map_pkg::grp_dt1_mul;
            opm_map_pkg::base_tl:       addr_grp = opm_map_pkg::grp_tl;
            opm_map_pkg::base_ks_ar:    addr_grp = opm_map_pkg::grp_ks_ar;
            opm_map_pkg::base_amen_d1r: addr_grp = opm_map_pkg::grp_amen_d1r;
            opm_map_pkg::base_dt2_d2r:  addr_grp = opm_map_pkg::grp_dt2_d2r;
            opm_map_pkg::base_d1l_rr:   addr_grp = opm_map_pkg::grp_d1l_rr;
            default:                    addr_is_op = 1'b0;
        endcase
    end

    // static low registers, loaded on the data strobe
    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            o_ne    <= 1'b0;
            o_nfrq  <= '0;
            o_clka1 <= '0;
            o_clka2 <= '0;
            o_clkb  <= '0;
            o_lfrq  <= '0;
        end else if (data_stb) begin
            case (addr_q)
                opm_map_pkg::addr_noise: begin
                    o_ne   <= bus_byte[opm_map_pkg::ne_bit];
                    o_nfrq <= bus_byte[opm_map_pkg::nfrq_lsb +: opm_map_pkg::nfrq_w];
                end
                opm_map_pkg::addr_clka1: o_clka1 <= bus_byte;
                opm_map_pkg::addr_clka2: o_clka2 <= bus_byte[opm_map_pkg::clka2_w-1:0];
                opm_map_pkg::addr_clkb:  o_clkb  <= bus_byte;
                opm_map_pkg::addr_lfrq:  o_lfrq  <= bus_byte;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // slot counter and operator write FSM

    opm_slot_pkg::wr_state_e  wr_state;
    opm_map_pkg::group_e      pend_grp;
    opm_slot_pkg::slot_t      pend_slot;
    logic                     slot_hit;
    logic                     busy;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) o_slot_cnt <= '0;
        else o_slot_cnt <= o_slot_cnt + 1'b1;   // wraps at 32
    end

    assign slot_hit = (wr_state == opm_slot_pkg::wr_wait_slot) && (o_slot_cnt == pend_slot);
    assign busy     = (wr_state == opm_slot_pkg::wr_wait_slot);

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            wr_state  <= opm_slot_pkg::wr_idle;
            pend_grp  <= opm_map_pkg::grp_dt1_mul;
            pend_slot <= '0;
            o_wr_data <= '0;
        end else begin
            case (wr_state)
                opm_slot_pkg::wr_idle: begin
                    if (data_stb && addr_is_op) begin
                        pend_grp  <= addr_grp;
                        pend_slot <= addr_q[opm_slot_pkg::slot_w-1:0];
                        o_wr_data <= bus_byte;
                        wr_state  <= opm_slot_pkg::wr_wait_slot;
                    end
                end
                // data bytes arriving here are dropped
                opm_slot_pkg::wr_wait_slot: if (slot_hit) wr_state <= opm_slot_pkg::wr_idle;
                default: wr_state <= opm_slot_pkg::wr_idle;
            endcase
        end
    end

    always_comb begin
        o_grp_we = '0;
        if (slot_hit) o_grp_we[pend_grp] = 1'b1;
    end

    // status read, busy in bit 7
    assign o_d_oe = mrst_n & ~i_cs_n & ~i_rd_n & i_a0;
    assign o_d    = {busy, {(opm_map_pkg::data_w-1){1'b0}}};

    a_grp_we_onehot: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        $onehot0(o_grp_we));

    a_busy_after_data: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        $rose(busy) |-> $past(data_stb));

endmodule

`default_nettype wire

//--- logic/opm_map_pkg.sv
`default_nettype none

package opm_map_pkg;

    //////////////////////////////////////////////////
    // operator register groups
    // value is the bit index into the group enable vector
    typedef enum logic [2:0] {
        grp_dt1_mul  = 3'd0,   // 0x40
        grp_tl       = 3'd1,   // 0x60
        grp_ks_ar    = 3'd2,   // 0x80
        grp_amen_d1r = 3'd3,   // 0xA0
        grp_dt2_d2r  = 3'd4,   // 0xC0
        grp_d1l_rr   = 3'd5    // 0xE0
    } group_e;

    localparam int num_groups = 6;
    localparam int data_w     = 8;

    //////////////////////////////////////////////////
    // low register addresses
    localparam logic [7:0] addr_noise = 8'h0F;   // NE / NFRQ
    localparam logic [7:0] addr_clka1 = 8'h10;   // timer A high bits
    localparam logic [7:0] addr_clka2 = 8'h11;   // timer A low bits
    localparam logic [7:0] addr_clkb  = 8'h12;
    localparam logic [7:0] addr_lfrq  = 8'h18;

    // upper three address bits of each group
    localparam logic [2:0] base_dt1_mul  = 3'b010;
    localparam logic [2:0] base_tl       = 3'b011;
    localparam logic [2:0] base_ks_ar    = 3'b100;
    localparam logic [2:0] base_amen_d1r = 3'b101;
    localparam logic [2:0] base_dt2_d2r  = 3'b110;
    localparam logic [2:0] base_d1l_rr   = 3'b111;

    //////////////////////////////////////////////////
    // field widths
    localparam int dt1_w   = 3;
    localparam int mul_w   = 4;
    localparam int tl_w    = 7;
    localparam int ks_w    = 2;
    localparam int ar_w    = 5;
    localparam int d1r_w   = 5;
    localparam int dt2_w   = 2;
    localparam int d2r_w   = 5;
    localparam int d1l_w   = 4;
    localparam int rr_w    = 4;
    localparam int nfrq_w  = 5;
    localparam int clka2_w = 2;

    // field positions inside the data byte
    localparam int ne_bit   = 7;
    localparam int nfrq_lsb = 0;
    localparam int dt1_lsb  = 4;
    localparam int mul_lsb  = 0;
    localparam int tl_lsb   = 0;
    localparam int ks_lsb   = 6;
    localparam int ar_lsb   = 0;
    localparam int amen_bit = 7;
    localparam int d1r_lsb  = 0;
    localparam int dt2_lsb  = 6;
    localparam int d2r_lsb  = 0;
    localparam int d1l_lsb  = 4;
    localparam int rr_lsb   = 0;

endpackage

`default_nettype wire

//--- logic/opm_reg_top.sv
`timescale 1ns/10ps
`default_nettype none

module opm_reg_top (
    input  logic                                  i_EMUCLK,
    input  logic                                  mrst_n,
    input  logic                                  i_cs_n,
    input  logic                                  i_wr_n,
    input  logic                                  i_rd_n,
    input  logic                                  i_a0,
    input  logic [opm_map_pkg::data_w-1:0]        i_d,
    output logic [opm_map_pkg::data_w-1:0]        o_d,
    output logic                                  o_d_oe,
    output logic                                  o_ne,
    output logic [opm_map_pkg::nfrq_w-1:0]        o_nfrq,
    output logic [7:0]                            o_clka1,
    output logic [opm_map_pkg::clka2_w-1:0]       o_clka2,
    output logic [7:0]                            o_clkb,
    output logic [7:0]                            o_lfrq,
    output opm_slot_pkg::slot_t                   o_slot,
    output logic                                  o_slot_valid,
    output logic [opm_map_pkg::dt1_w-1:0]         o_dt1,
    output logic [opm_map_pkg::mul_w-1:0]         o_mul,
    output logic [opm_map_pkg::tl_w-1:0]          o_tl,
    output logic [opm_map_pkg::ks_w-1:0]          o_ks,
    output logic [opm_map_pkg::ar_w-1:0]          o_ar,
    output logic                                  o_amen,
    output logic [opm_map_pkg::d1r_w-1:0]         o_d1r,
    output logic [opm_map_pkg::dt2_w-1:0]         o_dt2,
    output logic [opm_map_pkg::d2r_w-1:0]         o_d2r,
    output logic [opm_map_pkg::d1l_w-1:0]         o_d1l,
    output logic [opm_map_pkg::rr_w-1:0]          o_rr
);

    logic [opm_map_pkg::data_w-1:0]                               wr_data;
    logic [opm_map_pkg::num_groups-1:0]                           grp_we;
    opm_slot_pkg::slot_t                                          slot_cnt;   // head slot
    logic [opm_map_pkg::num_groups-1:0][opm_map_pkg::data_w-1:0]  tails;

    bus_write_decoder bus_write_decoder_i (
        .i_EMUCLK   (i_EMUCLK),
        .mrst_n     (mrst_n),
        .i_cs_n     (i_cs_n),
        .i_wr_n     (i_wr_n),
        .i_rd_n     (i_rd_n),
        .i_a0       (i_a0),
        .i_d        (i_d),
        .o_d        (o_d),
        .o_d_oe     (o_d_oe),
        .o_ne       (o_ne),
        .o_nfrq     (o_nfrq),
        .o_clka1    (o_clka1),
        .o_clka2    (o_clka2),
        .o_clkb     (o_clkb),
        .o_lfrq     (o_lfrq),
        .o_wr_data  (wr_data),
        .o_grp_we   (grp_we),
        .o_slot_cnt (slot_cnt)
    );

    //////////////////////////////////////////////////
    // one ring per operator register group
    genvar g;
    generate
        for (g = 0; g < opm_map_pkg::num_groups; g++) begin : g_ring
            slot_param_ring slot_param_ring_i (
                .i_EMUCLK  (i_EMUCLK),
                .mrst_n    (mrst_n),
                .i_we      (grp_we[g]),
                .i_wr_data (wr_data),
                .o_tail    (tails[g])
            );
        end
    endgenerate

    slot_param_unpack slot_param_unpack_i (
        .i_EMUCLK     (i_EMUCLK),
        .mrst_n       (mrst_n),
        .i_slot_cnt   (slot_cnt),
        .i_tails      (tails),
        .o_slot       (o_slot),
        .o_slot_valid (o_slot_valid),
        .o_dt1        (o_dt1),
        .o_mul        (o_mul),
        .o_tl         (o_tl),
        .o_ks         (o_ks),
        .o_ar         (o_ar),
        .o_amen       (o_amen),
        .o_d1r        (o_d1r),
        .o_dt2        (o_dt2),
        .o_d2r        (o_d2r),
        .o_d1l        (o_d1l),
        .o_rr         (o_rr)
    );

endmodule

`default_nettype wire

//--- logic/opm_slot_pkg.sv
`default_nettype none

package opm_slot_pkg;

    //////////////////////////////////////////////////
    // slot sequencing

    // one operator per slot, 32 slots per sweep
    localparam int num_slots = 32;
    localparam int slot_w    = 5;

    typedef logic [slot_w-1:0] slot_t;

    //////////////////////////////////////////////////
    // operator write FSM
    // wr_wait_slot holds the write until the counter meets its slot
    typedef enum logic {
        wr_idle      = 1'b0,
        wr_wait_slot = 1'b1
    } wr_state_e;

endpackage

`default_nettype wire

//--- logic/slot_param_ring.sv
`timescale 1ns/10ps
`default_nettype none

module slot_param_ring (
    input  logic        i_EMUCLK,
    input  logic        mrst_n,
    input  logic        i_we,
    input  logic [7:0]  i_wr_data,
    output logic [7:0]  o_tail
);

    //////////////////////////////////////////////////
    // 32-stage recirculating ring
    // stage 0 is the head, the last stage the tail
    logic [7:0] stage [opm_slot_pkg::num_slots];

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            for (int i = 0; i < opm_slot_pkg::num_slots; i++) begin
                stage[i] <= '0;
            end
        end else begin
            // write insert, else wrap tail back to head
            stage[0] <= i_we ? i_wr_data : stage[opm_slot_pkg::num_slots-1];
            for (int i = 1; i < opm_slot_pkg::num_slots; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_tail = stage[opm_slot_pkg::num_slots-1];

endmodule

`default_nettype wire

//--- logic/slot_param_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module slot_param_unpack (
    input  logic                                                    i_EMUCLK,
    input  logic                                                    mrst_n,
    input  opm_slot_pkg::slot_t                                     i_slot_cnt,
    input  logic [opm_map_pkg::num_groups-1:0][opm_map_pkg::data_w-1:0] i_tails,
    output opm_slot_pkg::slot_t                                     o_slot,
    output logic                                                    o_slot_valid,
    output logic [opm_map_pkg::dt1_w-1:0]                           o_dt1,
    output logic [opm_map_pkg::mul_w-1:0]                           o_mul,
    output logic [opm_map_pkg::tl_w-1:0]                            o_tl,
    output logic [opm_map_pkg::ks_w-1:0]                            o_ks,
    output logic [opm_map_pkg::ar_w-1:0]                            o_ar,
    output logic                                                    o_amen,
    output logic [opm_map_pkg::d1r_w-1:0]                           o_d1r,
    output logic [opm_map_pkg::dt2_w-1:0]                           o_dt2,
    output logic [opm_map_pkg::d2r_w-1:0]                           o_d2r,
    output logic [opm_map_pkg::d1l_w-1:0]                           o_d1l,
    output logic [opm_map_pkg::rr_w-1:0]                            o_rr
);

    //////////////////////////////////////////////////
    // output stage
    // tail words and slot tag move together
    logic [opm_map_pkg::num_groups-1:0][opm_map_pkg::data_w-1:0] tail_q;

    always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
        if (!mrst_n) begin
            tail_q       <= '0;
            o_slot       <= '0;
            o_slot_valid <= 1'b0;
        end else begin
            tail_q       <= i_tails;
            o_slot       <= i_slot_cnt;
            o_slot_valid <= 1'b1;   // first cycle out of reset
        end
    end

    //////////////////////////////////////////////////
    // field split, per register map
    assign o_dt1  = tail_q[opm_map_pkg::grp_dt1_mul][opm_map_pkg::dt1_lsb +: opm_map_pkg::dt1_w];
    assign o_mul  = tail_q[opm_map_pkg::grp_dt1_mul][opm_map_pkg::mul_lsb +: opm_map_pkg::mul_w];
    assign o_tl   = tail_q[opm_map_pkg::grp_tl][opm_map_pkg::tl_lsb +: opm_map_pkg::tl_w];
    assign o_ks   = tail_q[opm_map_pkg::grp_ks_ar][opm_map_pkg::ks_lsb +: opm_map_pkg::ks_w];
    assign o_ar   = tail_q[opm_map_pkg::grp_ks_ar][opm_map_pkg::ar_lsb +: opm_map_pkg::ar_w];
    assign o_amen = tail_q[opm_map_pkg::grp_amen_d1r][opm_map_pkg::amen_bit];
    assign o_d1r  = tail_q[opm_map_pkg::grp_amen_d1r][opm_map_pkg::d1r_lsb +: opm_map_pkg::d1r_w];
    assign o_dt2  = tail_q[opm_map_pkg::grp_dt2_d2r][opm_map_pkg::dt2_lsb +: opm_map_pkg::dt2_w];
    assign o_d2r  = tail_q[opm_map_pkg::grp_dt2_d2r][opm_map_pkg::d2r_lsb +: opm_map_pkg::d2r_w];
    assign o_d1l  = tail_q[opm_map_pkg::grp_d1l_rr][opm_map_pkg::d1l_lsb +: opm_map_pkg::d1l_w];
    assign o_rr   = tail_q[opm_map_pkg::grp_d1l_rr][opm_map_pkg::rr_lsb +: opm_map_pkg::rr_w];

    // slot tag follows the free-running counter with no gaps
    a_slot_step: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
        o_slot_valid |=> o_slot == opm_slot_pkg::slot_t'($past(o_slot) + 1'b1));

endmodule

`default_nettype wire

//--- opm_reg_top.f
logic/opm_map_pkg.sv
logic/opm_slot_pkg.sv
logic/bus_write_decoder.sv
logic/slot_param_ring.sv
logic/slot_param_unpack.sv
logic/opm_reg_top.sv
test/clock_gen.sv
test/opm_reg_top_tb.sv

//--- test/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    // held for 10 cycles, released on a falling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/opm_reg_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module opm_reg_top_tb;

    typedef enum int {
        fld_dt1, fld_mul, fld_tl, fld_ks, fld_ar, fld_amen,
        fld_d1r, fld_dt2, fld_d2r, fld_d1l, fld_rr
    } field_e;

    localparam int num_ops        = 40;
    localparam int num_bus_writes = 10 + 2 * num_ops + 6;   // low, random, busy tests
    localparam int timeout_cycles = num_bus_writes * 60 + 400;

    logic                                 i_EMUCLK;
    logic                                 mrst_n;
    logic                                 i_cs_n;
    logic                                 i_wr_n;
    logic                                 i_rd_n;
    logic                                 i_a0;
    logic [opm_map_pkg::data_w-1:0]       i_d;
    logic [opm_map_pkg::data_w-1:0]       o_d;
    logic                                 o_d_oe;
    logic                                 o_ne;
    logic [opm_map_pkg::nfrq_w-1:0]       o_nfrq;
    logic [7:0]                           o_clka1;
    logic [opm_map_pkg::clka2_w-1:0]      o_clka2;
    logic [7:0]                           o_clkb;
    logic [7:0]                           o_lfrq;
    logic [opm_slot_pkg::slot_w-1:0]      o_slot;
    logic                                 o_slot_valid;
    logic [opm_map_pkg::dt1_w-1:0]        o_dt1;
    logic [opm_map_pkg::mul_w-1:0]        o_mul;
    logic [opm_map_pkg::tl_w-1:0]         o_tl;
    logic [opm_map_pkg::ks_w-1:0]         o_ks;
    logic [opm_map_pkg::ar_w-1:0]         o_ar;
    logic                                 o_amen;
    logic [opm_map_pkg::d1r_w-1:0]        o_d1r;
    logic [opm_map_pkg::dt2_w-1:0]        o_dt2;
    logic [opm_map_pkg::d2r_w-1:0]        o_d2r;
    logic [opm_map_pkg::d1l_w-1:0]        o_d1l;
    logic [opm_map_pkg::rr_w-1:0]         o_rr;

    // reference model of the rings and the low registers
    logic [7:0] model [opm_map_pkg::num_groups][opm_slot_pkg::num_slots];
    int         exp_ne, exp_nfrq, exp_clka1, exp_clka2, exp_clkb, exp_lfrq;
    logic [15:0] lfsr;
    int         mismatch_count;
    int         failure_count;
    logic       sweep_on;   // high from the first clock out of reset
    int         exp_slot;

    clock_gen clock_gen_i (
        .o_clk   (i_EMUCLK),
        .o_rst_n (mrst_n)
    );

    opm_reg_top opm_reg_top_i (
        .i_EMUCLK     (i_EMUCLK),
        .mrst_n       (mrst_n),
        .i_cs_n       (i_cs_n),
        .i_wr_n       (i_wr_n),
        .i_rd_n       (i_rd_n),
        .i_a0         (i_a0),
        .i_d          (i_d),
        .o_d          (o_d),
        .o_d_oe       (o_d_oe),
        .o_ne         (o_ne),
        .o_nfrq       (o_nfrq),
        .o_clka1      (o_clka1),
        .o_clka2      (o_clka2),
        .o_clkb       (o_clkb),
        .o_lfrq       (o_lfrq),
        .o_slot       (o_slot),
        .o_slot_valid (o_slot_valid),
        .o_dt1        (o_dt1),
        .o_mul        (o_mul),
        .o_tl         (o_tl),
        .o_ks         (o_ks),
        .o_ar         (o_ar),
        .o_amen       (o_amen),
        .o_d1r        (o_d1r),
        .o_dt2        (o_dt2),
        .o_d2r        (o_d2r),
        .o_d1l        (o_d1l),
        .o_rr         (o_rr)
    );

    //////////////////////////////////////////////////
    // random source and reference model

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int field_of(input logic [7:0] b, input int lsb, input int width);
        return (b >> lsb) & ((1 << width) - 1);
    endfunction

    function automatic int expected_field(input int slot, input field_e fld);
        logic [7:0] b [opm_map_pkg::num_groups];
        for (int g = 0; g < opm_map_pkg::num_groups; g++) begin
            b[g] = model[g][slot];
        end
        case (fld)
            fld_dt1:  return field_of(b[opm_map_pkg::grp_dt1_mul],
                                      opm_map_pkg::dt1_lsb, opm_map_pkg::dt1_w);
            fld_mul:  return field_of(b[opm_map_pkg::grp_dt1_mul],
                                      opm_map_pkg::mul_lsb, opm_map_pkg::mul_w);
            fld_tl:   return field_of(b[opm_map_pkg::grp_tl],
                                      opm_map_pkg::tl_lsb, opm_map_pkg::tl_w);
            fld_ks:   return field_of(b[opm_map_pkg::grp_ks_ar],
                                      opm_map_pkg::ks_lsb, opm_map_pkg::ks_w);
            fld_ar:   return field_of(b[opm_map_pkg::grp_ks_ar],
                                      opm_map_pkg::ar_lsb, opm_map_pkg::ar_w);
            fld_amen: return field_of(b[opm_map_pkg::grp_amen_d1r], opm_map_pkg::amen_bit, 1);
            fld_d1r:  return field_of(b[opm_map_pkg::grp_amen_d1r],
                                      opm_map_pkg::d1r_lsb, opm_map_pkg::d1r_w);
            fld_dt2:  return field_of(b[opm_map_pkg::grp_dt2_d2r],
                                      opm_map_pkg::dt2_lsb, opm_map_pkg::dt2_w);
            fld_d2r:  return field_of(b[opm_map_pkg::grp_dt2_d2r],
                                      opm_map_pkg::d2r_lsb, opm_map_pkg::d2r_w);
            fld_d1l:  return field_of(b[opm_map_pkg::grp_d1l_rr],
                                      opm_map_pkg::d1l_lsb, opm_map_pkg::d1l_w);
            fld_rr:   return field_of(b[opm_map_pkg::grp_d1l_rr],
                                      opm_map_pkg::rr_lsb, opm_map_pkg::rr_w);
            default:  return 0;
        endcase
    endfunction

    function automatic logic [7:0] operator_addr(input int grp, input int slot);
        logic [2:0] base;
        case (grp)
            opm_map_pkg::grp_dt1_mul:  base = opm_map_pkg::base_dt1_mul;
            opm_map_pkg::grp_tl:       base = opm_map_pkg::base_tl;
            opm_map_pkg::grp_ks_ar:    base = opm_map_pkg::base_ks_ar;
            opm_map_pkg::grp_amen_d1r: base = opm_map_pkg::base_amen_d1r;
            opm_map_pkg::grp_dt2_d2r:  base = opm_map_pkg::base_dt2_d2r;
            default:                   base = opm_map_pkg::base_d1l_rr;
        endcase
        return {base, 5'(slot)};
    endfunction

    //////////////////////////////////////////////////
    // checks

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic match_slot(input int slot);
        compare_value("o_dt1", expected_field(slot, fld_dt1), o_dt1);
        compare_value("o_mul", expected_field(slot, fld_mul), o_mul);
        compare_value("o_tl", expected_field(slot, fld_tl), o_tl);
        compare_value("o_ks", expected_field(slot, fld_ks), o_ks);
        compare_value("o_ar", expected_field(slot, fld_ar), o_ar);
        compare_value("o_amen", expected_field(slot, fld_amen), o_amen);
        compare_value("o_d1r", expected_field(slot, fld_d1r), o_d1r);
        compare_value("o_dt2", expected_field(slot, fld_dt2), o_dt2);
        compare_value("o_d2r", expected_field(slot, fld_d2r), o_d2r);
        compare_value("o_d1l", expected_field(slot, fld_d1l), o_d1l);
        compare_value("o_rr", expected_field(slot, fld_rr), o_rr);
    endtask

    task automatic confirm_low_regs();
        compare_value("o_ne", exp_ne, o_ne);
        compare_value("o_nfrq", exp_nfrq, o_nfrq);
        compare_value("o_clka1", exp_clka1, o_clka1);
        compare_value("o_clka2", exp_clka2, o_clka2);
        compare_value("o_clkb", exp_clkb, o_clkb);
        compare_value("o_lfrq", exp_lfrq, o_lfrq);
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    endtask

    always @(posedge i_EMUCLK) begin
        sweep_on <= mrst_n;
    end

    // outputs are registered, so the falling edge sees them settled
    // slot tag starts at 0 and steps once a cycle
    always @(negedge i_EMUCLK) begin
        if (sweep_on) begin
            compare_value("o_slot_valid", 1, o_slot_valid);
            compare_value("o_slot", exp_slot, o_slot);
            match_slot(exp_slot);
            exp_slot = (exp_slot + 1) % opm_slot_pkg::num_slots;
        end
    end

    //////////////////////////////////////////////////
    // bus access

    // 3 cycles strobe low, 4 cycles gap
    task automatic bus_write(input logic a0, input logic [7:0] data);
        @(negedge i_EMUCLK);
        i_a0   = a0;
        i_d    = data;
        i_cs_n = 1'b0;
        i_wr_n = 1'b0;
        #1;
        compare_value("o_d_oe", 0, o_d_oe);   // no drive during a write
        repeat (3) @(negedge i_EMUCLK);
        i_wr_n = 1'b1;
        i_cs_n = 1'b1;
        repeat (4) @(negedge i_EMUCLK);
    endtask

    // status read held low, sampled once a cycle until busy drops
    task automatic wait_not_busy(output logic busy_seen);
        int   cycles;
        logic busy;
        @(negedge i_EMUCLK);
        i_cs_n = 1'b0;
        i_rd_n = 1'b0;
        i_a0   = 1'b1;
        cycles = 0;
        #1;
        compare_value("o_d_oe", 1, o_d_oe);
        compare_value("o_d[6:0]", 0, o_d[6:0]);
        busy      = o_d[7];
        busy_seen = busy;
        while (busy && cycles < 40) begin
            @(negedge i_EMUCLK);
            #1;
            busy = o_d[7];
            cycles++;
        end
        assert (!busy) else begin
            failure_count++;
            $display("error at %0t: busy flag still set after 40 cycles", $time);
        end
        @(negedge i_EMUCLK);
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // test sequences

    task automatic write_low_register(input logic [7:0] addr);
        logic [7:0] v;
        v = random_bits(8);
        bus_write(1'b0, addr);
        bus_write(1'b1, v);
        case (addr)
            opm_map_pkg::addr_noise: begin
                exp_ne   = v[7];
                exp_nfrq = v[4:0];
            end
            opm_map_pkg::addr_clka1: exp_clka1 = v;
            opm_map_pkg::addr_clka2: exp_clka2 = v[1:0];
            opm_map_pkg::addr_clkb:  exp_clkb  = v;
            default:                 exp_lfrq  = v;
        endcase
        confirm_low_regs();
    endtask

    task automatic random_operator_writes();
        int         grp;
        int         slot;
        logic [7:0] data;
        logic       busy_seen;
        for (int n = 0; n < num_ops; n++) begin
            grp  = int'(random_bits(3)) % opm_map_pkg::num_groups;
            slot = random_bits(5);
            data = random_bits(8);
            bus_write(1'b0, operator_addr(grp, slot));
            bus_write(1'b1, data);
            wait_not_busy(busy_seen);
            model[grp][slot] = data;
            repeat (33) @(negedge i_EMUCLK);   // one full sweep
        end
    endtask

    // target slot far ahead of the counter keeps busy up for a while
    task automatic busy_flag_status();
        int         grp;
        int         slot;
        logic [7:0] data;
        logic       busy_seen;
        @(negedge i_EMUCLK);
        slot = (o_slot + 25) % opm_slot_pkg::num_slots;
        grp  = int'(random_bits(3)) % opm_map_pkg::num_groups;
        data = random_bits(8);
        bus_write(1'b0, operator_addr(grp, slot));
        bus_write(1'b1, data);
        wait_not_busy(busy_seen);
        compare_value("o_d[7]", 1, busy_seen);
        model[grp][slot] = data;
        repeat (33) @(negedge i_EMUCLK);
    endtask

    task automatic dropped_write_while_busy();
        int         grp;
        int         slot;
        logic [7:0] data;
        logic       busy_seen;
        @(negedge i_EMUCLK);
        slot = (o_slot + 31) % opm_slot_pkg::num_slots;
        grp  = int'(random_bits(3)) % opm_map_pkg::num_groups;
        data = random_bits(8);
        bus_write(1'b0, operator_addr(grp, slot));
        bus_write(1'b1, data);
        // second pair lands while the first is still pending
        bus_write(1'b0, operator_addr((grp + 1) % 6, (slot + 7) % 32));
        bus_write(1'b1, ~model[(grp + 1) % 6][(slot + 7) % 32]);
        wait_not_busy(busy_seen);
        model[grp][slot] = data;
        repeat (33) @(negedge i_EMUCLK);
    endtask

    initial begin
        i_cs_n         = 1'b1;
        i_wr_n         = 1'b1;
        i_rd_n         = 1'b1;
        i_a0           = 1'b0;
        i_d            = '0;
        lfsr           = 16'd62;
        mismatch_count = 0;
        failure_count  = 0;
        exp_slot       = 0;
        exp_ne         = 0;
        exp_nfrq       = 0;
        exp_clka1      = 0;
        exp_clka2      = 0;
        exp_clkb       = 0;
        exp_lfrq       = 0;
        for (int g = 0; g < opm_map_pkg::num_groups; g++) begin
            for (int s = 0; s < opm_slot_pkg::num_slots; s++) begin
                model[g][s] = 8'h00;
            end
        end
        repeat (2) @(negedge i_EMUCLK);
        compare_value("o_slot_valid", 0, o_slot_valid);   // still in reset
        @(posedge mrst_n);
        @(negedge i_EMUCLK);
        compare_value("o_slot_valid", 1, o_slot_valid);
        compare_value("o_slot", 0, o_slot);
        confirm_low_regs();
        repeat (33) @(negedge i_EMUCLK);   // zero sweep

        // read strobe with a0 low must not drive the bus
        i_cs_n = 1'b0;
        i_rd_n = 1'b0;
        #1;
        compare_value("o_d_oe", 0, o_d_oe);
        @(negedge i_EMUCLK);
        i_cs_n = 1'b1;
        i_rd_n = 1'b1;

        write_low_register(opm_map_pkg::addr_noise);
        write_low_register(opm_map_pkg::addr_clka1);
        write_low_register(opm_map_pkg::addr_clka2);
        write_low_register(opm_map_pkg::addr_clkb);
        write_low_register(opm_map_pkg::addr_lfrq);
        random_operator_writes();
        busy_flag_status();
        dropped_write_while_busy();
        confirm_low_regs();

        report_counts();
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge i_EMUCLK);
        failure_count++;
        $display("error at %0t: run did not finish within %0d cycles", $time, timeout_cycles);
        report_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
